/* verilog/conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

////////////////////////////////////////////////////////////
// array geometry
////////////////////////////////////////////////////////////

// pixels packed into one input word
`define PIXELS_IN_ROW 32
`define PIXELS_IN_ROW_2POW 5

// line buffers, so one tile is this many output rows high
`define BUFFERS_NUM 3

// rows per pass, 64 for 8-bit data and 128 for 1-bit data
`define ROW_NUM_MODE0_2POW 6
`define ROW_NUM_MODE1_2POW 7

////////////////////////////////////////////////////////////
// field widths
////////////////////////////////////////////////////////////

`define INSTR_W 128

// shape fields and base addresses
`define DIM_W 16

// tile word and row counts, split sizes
`define CNT_W 8

`endif

/* verilog/conv_pkg.sv */
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

  // opcode lives in the top nibble of every word
  typedef enum logic [3:0] {
    OP_NOP       = 4'h0,
    OP_CONV_GEOM = 4'h1,
    OP_CONV_ADDR = 4'h2
  } opcode_t;

  // layer shape view
  typedef struct packed {
    opcode_t opcode;
    logic mode;
    logic [3:0] k;
    logic [3:0] s;
    logic [3:0] p;
    logic [3:0] nif_in_2pow;
    logic [3:0] ix_in_2pow;
    logic [`DIM_W-1:0] of;
    logic [`DIM_W-1:0] ox;
    logic [`DIM_W-1:0] oy;
    logic [`DIM_W-1:0] ix;
    logic [`DIM_W-1:0] iy;
    logic [`DIM_W-1:0] nif;
    logic [`INSTR_W-25-6*`DIM_W-1:0] pad;
  } conv_geom_t;

  // base address view
  typedef struct packed {
    opcode_t opcode;
    logic [`DIM_W-1:0] bias_base;
    logic [`DIM_W-1:0] tail_base;
    logic [`DIM_W-1:0] rank_base;
    logic [`DIM_W-1:0] weights_ddr_base;
    logic [`DIM_W-1:0] input_ddr_base;
    logic [`INSTR_W-4-5*`DIM_W-1:0] pad;
  } conv_addr_t;

  // one host word, read through whichever view the opcode selects
  typedef union packed {
    conv_geom_t geom;
    conv_addr_t addr;
  } conv_instr_u;

endpackage

`default_nettype wire

/* verilog/conv_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

// latched layer shape, valid for one cycle per layer
interface conv_geom_if;
  logic valid;
  logic mode;
  logic [3:0] k, s, p;
  logic [`DIM_W-1:0] of, ox, oy, ix, iy, nif;
  logic [3:0] nif_in_2pow, ix_in_2pow;
  logic [`DIM_W-1:0] nif_k_k;
  // ceil(of / rows per pass)
  logic [`CNT_W-1:0] of_div;

  modport source (output valid, mode, k, s, p, of, ox, oy, ix, iy, nif,
                  nif_in_2pow, ix_in_2pow, nif_k_k, of_div);
  modport sink (input valid, mode, k, s, p, of, ox, oy, ix, iy, nif,
                nif_in_2pow, ix_in_2pow, nif_k_k, of_div);
endinterface

// x plan, in input words
interface tile_x_if;
  logic valid;
  logic [`CNT_W-1:0] first_words, last_words, mid_words;
  logic [`DIM_W-1:0] ix_chunks, ox_chunks;

  modport source (output valid, first_words, last_words, mid_words, ix_chunks, ox_chunks);
  modport sink (input valid, first_words, last_words, mid_words, ix_chunks, ox_chunks);
endinterface

// y plan, in input rows
interface tile_y_if;
  logic valid;
  logic [`CNT_W-1:0] first_rows, last_rows, mid_rows;
  logic [`DIM_W-1:0] iy_chunks, oy_chunks;

  modport source (output valid, first_rows, last_rows, mid_rows, iy_chunks, oy_chunks);
  modport sink (input valid, first_rows, last_rows, mid_rows, iy_chunks, oy_chunks);
endinterface

`default_nettype wire

/* verilog/instr_latch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module instr_latch
  import conv_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire logic instr_valid,
  input wire conv_instr_u instr,
  output logic [`DIM_W-1:0] bias_layer_base_buf_adr_rd,
  output logic [`DIM_W-1:0] tail_layer_base_buf_adr_rd,
  output logic [`DIM_W-1:0] rank_layer_base_buf_adr_rd,
  output logic [`DIM_W-1:0] weights_layer_base_ddr_adr_rd,
  output logic [`DIM_W-1:0] input_ddr_layer_base_adr,
  conv_geom_if.source geom
);

  localparam int ROW0_MASK = (1 << `ROW_NUM_MODE0_2POW) - 1;
  localparam int ROW1_MASK = (1 << `ROW_NUM_MODE1_2POW) - 1;

  opcode_t opcode;
  logic geom_word;
  logic addr_word;
  logic [2:0] row_log2;
  logic [`DIM_W:0] row_mask;
  logic [`DIM_W:0] of_sum;
  logic [`DIM_W-1:0] nif_k_k_next;

  assign opcode = instr.geom.opcode;
  assign geom_word = instr_valid && (opcode == OP_CONV_GEOM);
  assign addr_word = instr_valid && (opcode == OP_CONV_ADDR);

  // ceil(of / row count): add row count - 1, then shift
  assign row_log2 = instr.geom.mode ? 3'(`ROW_NUM_MODE1_2POW) : 3'(`ROW_NUM_MODE0_2POW);
  assign row_mask = instr.geom.mode ? ROW1_MASK[`DIM_W:0] : ROW0_MASK[`DIM_W:0];
  assign of_sum = {1'b0, instr.geom.of} + row_mask;

  assign nif_k_k_next = instr.geom.nif * instr.geom.k * instr.geom.k;

  ////////////////////////////////////////////////////////////
  // base addresses and geometry strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      bias_layer_base_buf_adr_rd <= '0;
      tail_layer_base_buf_adr_rd <= '0;
      rank_layer_base_buf_adr_rd <= '0;
      weights_layer_base_ddr_adr_rd <= '0;
      input_ddr_layer_base_adr <= '0;
      geom.valid <= 1'b0;
    end else begin
      geom.valid <= geom_word;
      if (addr_word) begin
        bias_layer_base_buf_adr_rd <= instr.addr.bias_base;
        tail_layer_base_buf_adr_rd <= instr.addr.tail_base;
        rank_layer_base_buf_adr_rd <= instr.addr.rank_base;
        weights_layer_base_ddr_adr_rd <= instr.addr.weights_ddr_base;
        input_ddr_layer_base_adr <= instr.addr.input_ddr_base;
      end
    end
  end

  // shape payload, qualified downstream by geom.valid
  always_ff @(posedge clk) begin
    if (geom_word) begin
      geom.mode <= instr.geom.mode;
      geom.k <= instr.geom.k;
      geom.s <= instr.geom.s;
      geom.p <= instr.geom.p;
      geom.of <= instr.geom.of;
      geom.ox <= instr.geom.ox;
      geom.oy <= instr.geom.oy;
      geom.ix <= instr.geom.ix;
      geom.iy <= instr.geom.iy;
      geom.nif <= instr.geom.nif;
      geom.nif_in_2pow <= instr.geom.nif_in_2pow;
      geom.ix_in_2pow <= instr.geom.ix_in_2pow;
      geom.nif_k_k <= nif_k_k_next;
      geom.of_div <= of_sum[row_log2 +: `CNT_W];
    end
  end

  // host must only strobe words it knows how to encode
  assert property (@(posedge clk) disable iff (reset)
    instr_valid |-> opcode inside {OP_NOP, OP_CONV_GEOM, OP_CONV_ADDR})
    else $error("instr_latch: unknown opcode %0h", opcode);

endmodule

`default_nettype wire

/* verilog/tilex_planner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tilex_planner (
  input wire logic clk,
  input wire logic reset,
  conv_geom_if.sink geom,
  tile_x_if.source tx
);

  localparam logic [`DIM_W-1:0] PIX_M1 = `DIM_W'(`PIXELS_IN_ROW - 1);

  logic [`PIXELS_IN_ROW_2POW-1:0] ox_rem;
  logic [`DIM_W-1:0] reach_first;
  logic [`DIM_W-1:0] reach_last;
  logic [`DIM_W:0] ix_sum;
  logic [`DIM_W:0] ox_sum;

  // input pixels touched by a full tile, pre-rounded up to a word
  assign reach_first = PIX_M1 * geom.s + geom.k - geom.p + PIX_M1;

  // the last tile only covers ox mod PIXELS_IN_ROW outputs
  assign ox_rem = geom.ox[`PIXELS_IN_ROW_2POW-1:0];
  assign reach_last = (`DIM_W'(ox_rem) - 1'b1) * geom.s + geom.k - geom.p + PIX_M1;

  assign ix_sum = {1'b0, geom.ix} + PIX_M1;
  assign ox_sum = {1'b0, geom.ox} + PIX_M1;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx.valid <= 1'b0;
    end else begin
      tx.valid <= geom.valid;
    end
  end

  always_ff @(posedge clk) begin
    tx.first_words <= reach_first[`PIXELS_IN_ROW_2POW +: `CNT_W];
    if (ox_rem == '0) begin
      tx.last_words <= '0;
    end else begin
      tx.last_words <= reach_last[`PIXELS_IN_ROW_2POW +: `CNT_W];
    end
    tx.mid_words <= `CNT_W'(geom.s);
    tx.ix_chunks <= `DIM_W'(ix_sum >> `PIXELS_IN_ROW_2POW);
    tx.ox_chunks <= `DIM_W'(ox_sum >> `PIXELS_IN_ROW_2POW);
  end

endmodule

`default_nettype wire

/* verilog/tiley_planner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tiley_planner (
  input wire logic clk,
  input wire logic reset,
  conv_geom_if.sink geom,
  tile_y_if.source ty
);

  localparam logic [`DIM_W-1:0] BUF_N = `DIM_W'(`BUFFERS_NUM);

  logic [`DIM_W-1:0] oy_rem;
  logic [`DIM_W-1:0] first_rows;
  logic [`DIM_W:0] iy_sum;
  logic [`DIM_W:0] oy_sum;

  // BUFFERS_NUM is not a power of two, so these map to constant dividers
  assign oy_rem = geom.oy % BUF_N;
  assign iy_sum = {1'b0, geom.iy} + BUF_N - 1'b1;
  assign oy_sum = {1'b0, geom.oy} + BUF_N - 1'b1;

  // first tile also needs the kernel halo above it
  assign first_rows = (BUF_N - 1'b1) * geom.s + geom.k - geom.p;

  always_ff @(posedge clk) begin
    if (reset) begin
      ty.valid <= 1'b0;
    end else begin
      ty.valid <= geom.valid;
    end
  end

  always_ff @(posedge clk) begin
    ty.first_rows <= `CNT_W'(first_rows);
    ty.last_rows <= `CNT_W'(oy_rem * geom.s);
    ty.mid_rows <= `CNT_W'(BUF_N * geom.s);
    ty.iy_chunks <= `DIM_W'(iy_sum / BUF_N);
    ty.oy_chunks <= `DIM_W'(oy_sum / BUF_N);
  end

  // a zero stride would collapse every row count
  assert property (@(posedge clk) disable iff (reset) geom.valid |-> geom.s != '0)
    else $error("tiley_planner: stride of zero in layer shape");

endmodule

`default_nettype wire

/* verilog/split_sizer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module split_sizer (
  input wire logic clk,
  input wire logic reset,
  conv_geom_if.sink geom,
  tile_x_if.sink tx,
  tile_y_if.sink ty,
  output logic conv_start,
  output logic mode,
  output logic [3:0] k, s, p,
  output logic [`DIM_W-1:0] of, ox, oy, ix, iy, nif,
  output logic [3:0] nif_in_2pow, ix_in_2pow,
  output logic [`DIM_W-1:0] nif_mult_k_mult_k,
  output logic [`DIM_W-1:0] N_chunks,
  output logic [`CNT_W-1:0] of_div_row_num_ceil,
  output logic [`CNT_W-1:0] tiley_first_tilex_first_split_size,
  output logic [`CNT_W-1:0] tiley_first_tilex_last_split_size,
  output logic [`CNT_W-1:0] tiley_first_tilex_mid_split_size,
  output logic [`CNT_W-1:0] tiley_last_tilex_first_split_size,
  output logic [`CNT_W-1:0] tiley_last_tilex_last_split_size,
  output logic [`CNT_W-1:0] tiley_last_tilex_mid_split_size,
  output logic [`CNT_W-1:0] tiley_mid_tilex_first_split_size,
  output logic [`CNT_W-1:0] tiley_mid_tilex_last_split_size,
  output logic [`CNT_W-1:0] tiley_mid_tilex_mid_split_size,
  output logic [`CNT_W-1:0] tilex_first_ix_word_num, tilex_last_ix_word_num,
  output logic [`CNT_W-1:0] tilex_mid_ix_word_num,
  output logic [`CNT_W-1:0] tiley_first_iy_row_num, tiley_last_iy_row_num,
  output logic [`CNT_W-1:0] tiley_mid_iy_row_num,
  output logic [`DIM_W-1:0] ix_chunks_num, iy_chunks_num
);

  // mode, k, s, p, six shape fields, two log2 fields, nif*k*k
  localparam int PASS_W = 1 + 3 * 4 + 6 * `DIM_W + 2 * 4 + `DIM_W;

  logic [PASS_W-1:0] geom_d;
  logic [`CNT_W-1:0] of_div_d;
  logic fire;

  // ceil(rows * words / of_div), data of one split per output-row group
  function automatic logic [`CNT_W-1:0] split_size(input logic [`CNT_W-1:0] rows,
                                                   input logic [`CNT_W-1:0] words,
                                                   input logic [`CNT_W-1:0] div);
    logic [2*`CNT_W-1:0] prod;
    prod = rows * words;
    if (div == '0) begin
      return '0;
    end
    return `CNT_W'((prod + div - 1'b1) / div);
  endfunction

  assign fire = tx.valid && ty.valid;

  // shape waits one stage here so it meets the planner results
  always_ff @(posedge clk) begin
    if (geom.valid) begin
      geom_d <= {geom.mode, geom.k, geom.s, geom.p, geom.of, geom.ox, geom.oy, geom.ix,
                 geom.iy, geom.nif, geom.nif_in_2pow, geom.ix_in_2pow, geom.nif_k_k};
      of_div_d <= geom.of_div;
    end
  end

  ////////////////////////////////////////////////////////////
  // layer outputs, all loaded with the conv_start pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      conv_start <= 1'b0;
      {mode, k, s, p, of, ox, oy, ix, iy, nif, nif_in_2pow, ix_in_2pow,
       nif_mult_k_mult_k} <= {PASS_W{1'b0}};
      N_chunks <= '0;
      of_div_row_num_ceil <= '0;
      tiley_first_tilex_first_split_size <= '0;
      tiley_first_tilex_last_split_size <= '0;
      tiley_first_tilex_mid_split_size <= '0;
      tiley_last_tilex_first_split_size <= '0;
      tiley_last_tilex_last_split_size <= '0;
      tiley_last_tilex_mid_split_size <= '0;
      tiley_mid_tilex_first_split_size <= '0;
      tiley_mid_tilex_last_split_size <= '0;
      tiley_mid_tilex_mid_split_size <= '0;
      tilex_first_ix_word_num <= '0;
      tilex_last_ix_word_num <= '0;
      tilex_mid_ix_word_num <= '0;
      tiley_first_iy_row_num <= '0;
      tiley_last_iy_row_num <= '0;
      tiley_mid_iy_row_num <= '0;
      ix_chunks_num <= '0;
      iy_chunks_num <= '0;
    end else begin
      conv_start <= fire;
      if (fire) begin
        {mode, k, s, p, of, ox, oy, ix, iy, nif, nif_in_2pow, ix_in_2pow,
         nif_mult_k_mult_k} <= geom_d;
        N_chunks <= `DIM_W'(tx.ox_chunks * ty.oy_chunks * of_div_d);
        of_div_row_num_ceil <= of_div_d;
        tiley_first_tilex_first_split_size <= split_size(ty.first_rows, tx.first_words, of_div_d);
        tiley_first_tilex_last_split_size <= split_size(ty.first_rows, tx.last_words, of_div_d);
        tiley_first_tilex_mid_split_size <= split_size(ty.first_rows, tx.mid_words, of_div_d);
        tiley_last_tilex_first_split_size <= split_size(ty.last_rows, tx.first_words, of_div_d);
        tiley_last_tilex_last_split_size <= split_size(ty.last_rows, tx.last_words, of_div_d);
        tiley_last_tilex_mid_split_size <= split_size(ty.last_rows, tx.mid_words, of_div_d);
        tiley_mid_tilex_first_split_size <= split_size(ty.mid_rows, tx.first_words, of_div_d);
        tiley_mid_tilex_last_split_size <= split_size(ty.mid_rows, tx.last_words, of_div_d);
        tiley_mid_tilex_mid_split_size <= split_size(ty.mid_rows, tx.mid_words, of_div_d);
        tilex_first_ix_word_num <= tx.first_words;
        tilex_last_ix_word_num <= tx.last_words;
        tilex_mid_ix_word_num <= tx.mid_words;
        tiley_first_iy_row_num <= ty.first_rows;
        tiley_last_iy_row_num <= ty.last_rows;
        tiley_mid_iy_row_num <= ty.mid_rows;
        ix_chunks_num <= tx.ix_chunks;
        iy_chunks_num <= ty.iy_chunks;
      end
    end
  end

  // of_div comes from the latch two stages back, it must never be zero here
  assert property (@(posedge clk) disable iff (reset) tx.valid |-> of_div_d != '0)
    else $error("split_sizer: of_div is zero for a planned layer");

endmodule

`default_nettype wire

/* verilog/conv_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_decoder_top (
  input wire logic clk,
  input wire logic reset,
  input wire logic instr_valid,
  input wire logic [`INSTR_W-1:0] instr,
  output logic conv_start,
  output logic mode,
  output logic [3:0] k, s, p,
  output logic [`DIM_W-1:0] of, ox, oy, ix, iy, nif,
  output logic [3:0] nif_in_2pow, ix_in_2pow,
  output logic [`DIM_W-1:0] nif_mult_k_mult_k,
  output logic [`DIM_W-1:0] N_chunks,
  output logic [`DIM_W-1:0] bias_layer_base_buf_adr_rd,
  output logic [`DIM_W-1:0] tail_layer_base_buf_adr_rd,
  output logic [`DIM_W-1:0] rank_layer_base_buf_adr_rd,
  output logic [`DIM_W-1:0] weights_layer_base_ddr_adr_rd,
  output logic [`DIM_W-1:0] input_ddr_layer_base_adr,
  output logic [`CNT_W-1:0] of_div_row_num_ceil,
  output logic [`CNT_W-1:0] tiley_first_tilex_first_split_size,
  output logic [`CNT_W-1:0] tiley_first_tilex_last_split_size,
  output logic [`CNT_W-1:0] tiley_first_tilex_mid_split_size,
  output logic [`CNT_W-1:0] tiley_last_tilex_first_split_size,
  output logic [`CNT_W-1:0] tiley_last_tilex_last_split_size,
  output logic [`CNT_W-1:0] tiley_last_tilex_mid_split_size,
  output logic [`CNT_W-1:0] tiley_mid_tilex_first_split_size,
  output logic [`CNT_W-1:0] tiley_mid_tilex_last_split_size,
  output logic [`CNT_W-1:0] tiley_mid_tilex_mid_split_size,
  output logic [`CNT_W-1:0] tilex_first_ix_word_num, tilex_last_ix_word_num,
  output logic [`CNT_W-1:0] tilex_mid_ix_word_num,
  output logic [`CNT_W-1:0] tiley_first_iy_row_num, tiley_last_iy_row_num,
  output logic [`CNT_W-1:0] tiley_mid_iy_row_num,
  output logic [`DIM_W-1:0] ix_chunks_num, iy_chunks_num
);

  conv_geom_if geom ();
  tile_x_if tx ();
  tile_y_if ty ();

  // stage 1, decode and latch
  instr_latch u_instr_latch (.instr(instr), .*);

  // stage 2, x and y planned side by side
  tilex_planner u_tilex_planner (.*);
  tiley_planner u_tiley_planner (.*);

  // stage 3, split sizes and conv_start
  split_sizer u_split_sizer (.*);

endmodule

`default_nettype wire

/* bench/tb_conv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tb_conv_decoder
  import conv_pkg::*;
();

  localparam int RESET_CYCLES = 4;
  localparam int LATENCY = 3;
  localparam int START_LIMIT = 10;
  localparam int RANDOM_LAYERS = 20;
  // directed tests plus a few idle cycles per random layer
  localparam int TEST_CYCLES = RESET_CYCLES + 60 + RANDOM_LAYERS * 8;
  localparam int TIMEOUT_NS = TEST_CYCLES * 100 * 2;

  logic clk, reset, instr_valid;
  logic [`INSTR_W-1:0] instr;
  logic conv_start, mode;
  logic [3:0] k, s, p, nif_in_2pow, ix_in_2pow;
  logic [`DIM_W-1:0] of, ox, oy, ix, iy, nif, nif_mult_k_mult_k, N_chunks;
  logic [`DIM_W-1:0] bias_layer_base_buf_adr_rd, tail_layer_base_buf_adr_rd;
  logic [`DIM_W-1:0] rank_layer_base_buf_adr_rd, weights_layer_base_ddr_adr_rd;
  logic [`DIM_W-1:0] input_ddr_layer_base_adr, ix_chunks_num, iy_chunks_num;
  logic [`CNT_W-1:0] of_div_row_num_ceil;
  logic [`CNT_W-1:0] tiley_first_tilex_first_split_size, tiley_first_tilex_last_split_size;
  logic [`CNT_W-1:0] tiley_first_tilex_mid_split_size, tiley_last_tilex_first_split_size;
  logic [`CNT_W-1:0] tiley_last_tilex_last_split_size, tiley_last_tilex_mid_split_size;
  logic [`CNT_W-1:0] tiley_mid_tilex_first_split_size, tiley_mid_tilex_last_split_size;
  logic [`CNT_W-1:0] tiley_mid_tilex_mid_split_size;
  logic [`CNT_W-1:0] tilex_first_ix_word_num, tilex_last_ix_word_num, tilex_mid_ix_word_num;
  logic [`CNT_W-1:0] tiley_first_iy_row_num, tiley_last_iy_row_num, tiley_mid_iy_row_num;

  int cycle = 0;
  int word_cycle;
  int fail_count = 0;
  // expected output values in the order check_outputs reads them
  int exp_q[$];

  conv_decoder_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [31:0] actual, input int expected, input string name);
    if (actual !== expected) begin
      fail_count++;
      $display("FAIL at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  function automatic int ceil_div(input int a, input int b);
    return (a + b - 1) / b;
  endfunction

  // expected values of one layer from the tiling rules
  task automatic model_layer(input conv_geom_t g);
    int kk, ss, pp, row_cnt, of_div, oxr;
    int rows[3];
    int words[3];
    kk = g.k;
    ss = g.s;
    pp = g.p;
    row_cnt = g.mode ? (1 << `ROW_NUM_MODE1_2POW) : (1 << `ROW_NUM_MODE0_2POW);
    of_div = ceil_div(int'(g.of), row_cnt);
    oxr = g.ox % `PIXELS_IN_ROW;
    words[0] = ceil_div((`PIXELS_IN_ROW - 1) * ss + kk - pp, `PIXELS_IN_ROW);
    words[1] = (oxr == 0) ? 0 : ceil_div((oxr - 1) * ss + kk - pp, `PIXELS_IN_ROW);
    words[2] = ss;
    rows[0] = (`BUFFERS_NUM - 1) * ss + kk - pp;
    rows[1] = (g.oy % `BUFFERS_NUM) * ss;
    rows[2] = `BUFFERS_NUM * ss;
    exp_q.push_back(g.mode);
    exp_q.push_back(kk);
    exp_q.push_back(ss);
    exp_q.push_back(pp);
    exp_q.push_back(g.of);
    exp_q.push_back(g.ox);
    exp_q.push_back(g.oy);
    exp_q.push_back(g.ix);
    exp_q.push_back(g.iy);
    exp_q.push_back(g.nif);
    exp_q.push_back(g.nif_in_2pow);
    exp_q.push_back(g.ix_in_2pow);
    exp_q.push_back((g.nif * kk * kk) & 16'hffff);
    exp_q.push_back((ceil_div(g.ox, `PIXELS_IN_ROW) * ceil_div(g.oy, `BUFFERS_NUM)
                     * of_div) & 16'hffff);
    exp_q.push_back(of_div);
    for (int y = 0; y < 3; y++) begin
      for (int x = 0; x < 3; x++) begin
        exp_q.push_back(ceil_div(rows[y] * words[x], of_div));
      end
    end
    for (int x = 0; x < 3; x++) exp_q.push_back(words[x]);
    for (int y = 0; y < 3; y++) exp_q.push_back(rows[y]);
    exp_q.push_back(ceil_div(g.ix, `PIXELS_IN_ROW));
    exp_q.push_back(ceil_div(g.iy, `BUFFERS_NUM));
  endtask

  task automatic check_outputs();
    check_eq(mode, exp_q.pop_front(), "mode");
    check_eq(k, exp_q.pop_front(), "k");
    check_eq(s, exp_q.pop_front(), "s");
    check_eq(p, exp_q.pop_front(), "p");
    check_eq(of, exp_q.pop_front(), "of");
    check_eq(ox, exp_q.pop_front(), "ox");
    check_eq(oy, exp_q.pop_front(), "oy");
    check_eq(ix, exp_q.pop_front(), "ix");
    check_eq(iy, exp_q.pop_front(), "iy");
    check_eq(nif, exp_q.pop_front(), "nif");
    check_eq(nif_in_2pow, exp_q.pop_front(), "nif_in_2pow");
    check_eq(ix_in_2pow, exp_q.pop_front(), "ix_in_2pow");
    check_eq(nif_mult_k_mult_k, exp_q.pop_front(), "nif_mult_k_mult_k");
    check_eq(N_chunks, exp_q.pop_front(), "N_chunks");
    check_eq(of_div_row_num_ceil, exp_q.pop_front(), "of_div_row_num_ceil");
    check_eq(tiley_first_tilex_first_split_size, exp_q.pop_front(), "split first/first");
    check_eq(tiley_first_tilex_last_split_size, exp_q.pop_front(), "split first/last");
    check_eq(tiley_first_tilex_mid_split_size, exp_q.pop_front(), "split first/mid");
    check_eq(tiley_last_tilex_first_split_size, exp_q.pop_front(), "split last/first");
    check_eq(tiley_last_tilex_last_split_size, exp_q.pop_front(), "split last/last");
    check_eq(tiley_last_tilex_mid_split_size, exp_q.pop_front(), "split last/mid");
    check_eq(tiley_mid_tilex_first_split_size, exp_q.pop_front(), "split mid/first");
    check_eq(tiley_mid_tilex_last_split_size, exp_q.pop_front(), "split mid/last");
    check_eq(tiley_mid_tilex_mid_split_size, exp_q.pop_front(), "split mid/mid");
    check_eq(tilex_first_ix_word_num, exp_q.pop_front(), "tilex_first_ix_word_num");
    check_eq(tilex_last_ix_word_num, exp_q.pop_front(), "tilex_last_ix_word_num");
    check_eq(tilex_mid_ix_word_num, exp_q.pop_front(), "tilex_mid_ix_word_num");
    check_eq(tiley_first_iy_row_num, exp_q.pop_front(), "tiley_first_iy_row_num");
    check_eq(tiley_last_iy_row_num, exp_q.pop_front(), "tiley_last_iy_row_num");
    check_eq(tiley_mid_iy_row_num, exp_q.pop_front(), "tiley_mid_iy_row_num");
    check_eq(ix_chunks_num, exp_q.pop_front(), "ix_chunks_num");
    check_eq(iy_chunks_num, exp_q.pop_front(), "iy_chunks_num");
  endtask

  task automatic check_addrs(input int b, input int t, input int r, input int w, input int i);
    check_eq(bias_layer_base_buf_adr_rd, b, "bias base");
    check_eq(tail_layer_base_buf_adr_rd, t, "tail base");
    check_eq(rank_layer_base_buf_adr_rd, r, "rank base");
    check_eq(weights_layer_base_ddr_adr_rd, w, "weights ddr base");
    check_eq(input_ddr_layer_base_adr, i, "input ddr base");
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // inputs change 10 ns after each rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic drive_word(input logic [`INSTR_W-1:0] w);
    word_cycle = cycle;
    instr_valid = 1'b1;
    instr = w;
    next_cycle();
  endtask

  task automatic go_idle();
    instr_valid = 1'b0;
    instr = '0;
  endtask

  function automatic conv_geom_t make_geom(input int md, input int kk, input int ss,
                                           input int pp, input int f, input int x_o,
                                           input int y_o, input int x_i, input int y_i,
                                           input int n);
    conv_geom_t g;
    g = '0;
    g.opcode = OP_CONV_GEOM;
    g.mode = md[0];
    g.k = kk[3:0];
    g.s = ss[3:0];
    g.p = pp[3:0];
    g.of = f[15:0];
    g.ox = x_o[15:0];
    g.oy = y_o[15:0];
    g.ix = x_i[15:0];
    g.iy = y_i[15:0];
    g.nif = n[15:0];
    return g;
  endfunction

  // first_cycle is the cycle in which the layer's word was driven
  task automatic wait_start(input int first_cycle);
    int waited;
    for (waited = 0; waited < START_LIMIT && conv_start !== 1'b1; waited++) next_cycle();
    if (conv_start !== 1'b1) abort_run("conv_start never rose after a geometry word");
    else check_eq(cycle - first_cycle, LATENCY, "conv_start latency");
  endtask

  task automatic run_layer(input conv_geom_t g);
    model_layer(g);
    drive_word(g);
    go_idle();
    wait_start(word_cycle);
    check_outputs();
    next_cycle();
    check_eq(conv_start, 0, "conv_start after pulse");
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_eq(conv_start, 0, "conv_start after reset");
    repeat (32) exp_q.push_back(0);
    check_outputs();
    check_addrs(0, 0, 0, 0, 0);
  endtask

  task automatic test_reference_layer();
    conv_geom_t g;
    g = make_geom(0, 3, 1, 1, 128, 128, 3, 128, 3, 2);
    run_layer(g);
    check_eq(of_div_row_num_ceil, 2, "reference of_div");
    check_eq(N_chunks, 8, "reference N_chunks");
    check_eq(nif_mult_k_mult_k, 18, "reference nif*k*k");
    // values hold until the next layer
    model_layer(g);
    check_outputs();
  endtask

  task automatic test_mode1_layer();
    run_layer(make_geom(1, 3, 1, 1, 128, 128, 3, 128, 3, 2));
    check_eq(of_div_row_num_ceil, 1, "mode 1 of_div");
  endtask

  task automatic test_address_word();
    conv_addr_t a;
    a = '0;
    a.opcode = OP_CONV_ADDR;
    a.bias_base = 16'h1234;
    a.tail_base = 16'h0abc;
    a.rank_base = 16'h7f01;
    a.weights_ddr_base = 16'hc350;
    a.input_ddr_base = 16'h00ff;
    drive_word(a);
    go_idle();
    check_addrs('h1234, 'h0abc, 'h7f01, 'hc350, 'h00ff);
    repeat (LATENCY + 1) begin
      check_eq(conv_start, 0, "conv_start after address word");
      next_cycle();
    end
    run_layer(make_geom(0, 5, 2, 2, 300, 77, 10, 160, 25, 9));
    check_addrs('h1234, 'h0abc, 'h7f01, 'hc350, 'h00ff);
  endtask

  task automatic test_back_to_back();
    conv_geom_t g[3];
    int first_cycle;
    g[0] = make_geom(0, 3, 1, 1, 64, 40, 7, 42, 9, 4);
    g[1] = make_geom(1, 7, 3, 3, 1000, 511, 512, 500, 33, 300);
    g[2] = make_geom(0, 1, 2, 0, 65, 96, 6, 192, 12, 16);
    for (int i = 0; i < 3; i++) model_layer(g[i]);
    drive_word(g[0]);
    first_cycle = word_cycle;
    drive_word(g[1]);
    drive_word(g[2]);
    go_idle();
    wait_start(first_cycle);
    check_outputs();
    for (int i = 1; i < 3; i++) begin
      next_cycle();
      check_eq(conv_start, 1, "conv_start of pipelined layer");
      check_outputs();
    end
    next_cycle();
    check_eq(conv_start, 0, "conv_start after pipelined layers");
  endtask

  task automatic test_random_layers();
    conv_geom_t g;
    int kk;
    for (int n = 0; n < RANDOM_LAYERS; n++) begin
      kk = 1 + $urandom % 7;
      g = make_geom($urandom % 2, kk, 1 + $urandom % 3, $urandom % kk, 1 + $urandom % 1024,
                    1 + $urandom % 512, 1 + $urandom % 512, 1 + $urandom % 512,
                    1 + $urandom % 512, 1 + $urandom % 512);
      g.nif_in_2pow = 4'($urandom % 16);
      g.ix_in_2pow = 4'($urandom % 16);
      run_layer(g);
    end
  endtask

  initial begin
    void'($urandom(6));
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #10;
    reset = 1'b0;
    test_reset_state();
    test_reference_layer();
    test_mode1_layer();
    test_address_word();
    test_back_to_back();
    test_random_layers();
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    abort_run("simulation timed out before the tests finished");
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/conv_pkg.sv
verilog/conv_if.sv
verilog/instr_latch.sv
verilog/tilex_planner.sv
verilog/tiley_planner.sv
verilog/split_sizer.sv
verilog/conv_decoder_top.sv
bench/tb_conv_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_conv_decoder -f sim.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if grep -q "all tests passed" <<< "$output"; then
  exit 0
fi
exit 1
